// ==== include/core_trace_consts.svh ====
// Widths, field offsets and depths for the RV32I trace unit
// XLEN is fixed at 32, 32 registers, mepc word aligned
`ifndef CORE_TRACE_CONSTS_SVH
`define CORE_TRACE_CONSTS_SVH

// Core data
`define CT_XLEN              32
`define CT_REG_ADDR_W        5

// mstatus layout
`define CT_MSTATUS_MIE_BIT   3
`define CT_MSTATUS_MPIE_BIT  7
`define CT_MSTATUS_MPP_LSB   11
`define CT_MSTATUS_MPP_VAL   2'b11     // Machine mode only

// mie and mip share one layout
`define CT_MIX_MSI_BIT       3
`define CT_MIX_MTI_BIT       7
`define CT_MIX_MEI_BIT       11
`define CT_MCAUSE_EC_W       4

// Header word fields, register address sits in bits 4..0
`define CT_HDR_FIELD_W       4
`define CT_HDR_KIND_LSB      28
`define CT_HDR_LEN_LSB       16
`define CT_HDR_WR_BIT        8
`define CT_KIND_REG          1
`define CT_KIND_CSR          2

// Frame lengths include the header
`define CT_REG_WORDS         4
`define CT_CSR_WORDS         9

`define CT_REG_FIFO_DEPTH    8
`define CT_CSR_FIFO_DEPTH    4
`define CT_TX_CREDITS        8

`endif

// ==== logic/core_trace_pkg.sv ====
// Record types shared by capture, queues and transmitter
// Field order of each struct is the order of its frame body

`include "core_trace_consts.svh"

package core_trace_pkg;

    typedef logic [`CT_XLEN-1:0] xword_t;

    // --------------------------------------
    // Register-diff record
    // --------------------------------------
    typedef struct packed {
        xword_t                    stamp;    // Cycle of the event
        xword_t                    pc;
        logic                      wr;       // A register was written
        logic [`CT_REG_ADDR_W-1:0] addr;     // Zero when wr is low
        xword_t                    data;     // Zero when wr is low
    } reg_rec_t;

    // --------------------------------------
    // CSR snapshot and record
    // --------------------------------------
    typedef struct packed {
        xword_t mstatus;
        xword_t mtvec;
        xword_t mie;
        xword_t mip;
        xword_t mepc;
        xword_t mcause;
        xword_t mtval;
    } csr_snap_t;

    typedef struct packed {
        xword_t    stamp;
        csr_snap_t snap;
    } csr_rec_t;

endpackage

// ==== logic/trace_capture.sv ====
// Builds trace records from core events; never stalls the core
// Records leave one cycle after their event; a full queue drops the record
// and sets the sticky overflow flag until reset
`timescale 1ns/1ps

`include "core_trace_consts.svh"

module trace_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    // Register file and PC
    input  logic                          reg_wr_en,
    input  logic [`CT_REG_ADDR_W-1:0]     reg_wr_addr,
    input  logic [`CT_XLEN-1:0]           reg_wr_data,
    input  logic                          pc_update_en,
    input  logic [`CT_XLEN-1:0]           pc_update,
    input  logic                          mie_update,
    // CSR fields
    input  logic                          mstatus_mie,
    input  logic                          mstatus_mpie,
    input  logic [`CT_XLEN-1:6]           mtvec_base,
    input  logic                          mtvec_mode,
    input  logic                          mie_meie,
    input  logic                          mie_mtie,
    input  logic                          mie_msie,
    input  logic                          mip_meip,
    input  logic                          mip_mtip,
    input  logic                          mip_msip,
    input  logic [`CT_XLEN-1:2]           mepc,
    input  logic                          mcause_irq,
    input  logic [`CT_MCAUSE_EC_W-1:0]    mcause_ec,
    input  logic [`CT_XLEN-1:0]           mtval,
    // Queue side
    input  logic                          reg_full,
    input  logic                          csr_full,
    output logic                          reg_push,
    output core_trace_pkg::reg_rec_t      reg_rec,
    output logic                          csr_push,
    output core_trace_pkg::csr_rec_t      csr_rec,
    output logic                          overflow
);

    core_trace_pkg::xword_t    cycle_cnt;
    logic                      trace_ev;
    core_trace_pkg::csr_snap_t snap;
    core_trace_pkg::csr_snap_t snap_prev;
    logic                      csr_first;
    logic                      reg_pend;
    logic                      csr_pend;

    // --------------------------------------
    // Cycle stamp
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;                  // Reads 0 in the first cycle out of reset
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Writes tagged by mie_update alone are not retirements
    assign trace_ev = pc_update_en | (reg_wr_en & ~mie_update);

    // --------------------------------------
    // CSR snapshot assembly
    // --------------------------------------
    always_comb begin
        snap = '0;
        snap.mstatus[`CT_MSTATUS_MIE_BIT]      = mstatus_mie;
        snap.mstatus[`CT_MSTATUS_MPIE_BIT]     = mstatus_mpie;
        snap.mstatus[`CT_MSTATUS_MPP_LSB +: 2] = `CT_MSTATUS_MPP_VAL;
        snap.mtvec                             = {mtvec_base, 5'd0, mtvec_mode};
        snap.mie[`CT_MIX_MSI_BIT]              = mie_msie;
        snap.mie[`CT_MIX_MTI_BIT]              = mie_mtie;
        snap.mie[`CT_MIX_MEI_BIT]              = mie_meie;
        snap.mip[`CT_MIX_MSI_BIT]              = mip_msip;
        snap.mip[`CT_MIX_MTI_BIT]              = mip_mtip;
        snap.mip[`CT_MIX_MEI_BIT]              = mip_meip;
        snap.mepc                              = {mepc, 2'b00};
        snap.mcause[`CT_XLEN-1]                = mcause_irq;
        snap.mcause[`CT_MCAUSE_EC_W-1:0]       = mcause_ec;   // Zero extended
        snap.mtval                             = mtval;
    end

    // Previous snapshot, compared every cycle
    always_ff @(posedge clk) begin
        snap_prev <= snap;
    end

    // --------------------------------------
    // Record registers
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_first <= 1'b1;
            reg_pend  <= 1'b0;
            csr_pend  <= 1'b0;
        end else begin
            csr_first <= 1'b0;
            reg_pend  <= trace_ev;
            csr_pend  <= csr_first | (snap != snap_prev);
        end
    end

    always_ff @(posedge clk) begin
        reg_rec.stamp <= cycle_cnt;
        reg_rec.pc    <= pc_update;
        reg_rec.wr    <= reg_wr_en;
        reg_rec.addr  <= reg_wr_en ? reg_wr_addr : '0;
        reg_rec.data  <= reg_wr_en ? reg_wr_data : '0;
        csr_rec.stamp <= cycle_cnt;
        csr_rec.snap  <= snap;
    end

    assign reg_push = reg_pend & ~reg_full;
    assign csr_push = csr_pend & ~csr_full;

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if ((reg_pend & reg_full) | (csr_pend & csr_full)) begin
            overflow <= 1'b1;
        end
    end

    // A write strobe from the core must carry a known register index
    a_wr_addr_known : assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr_en |-> !$isunknown(reg_wr_addr));

endmodule

// ==== logic/trace_fifo.sv ====
// Synchronous record queue, head readable without delay
// Callers must not push when full or pop when empty
`timescale 1ns/1ps

module trace_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    // Producer holds records back while full
    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    // Consumer only loads a record that is there
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

// ==== logic/trace_port_tx.sv ====
// Serializes queued records into 32-bit words under sink credits
// Register queue wins at record boundaries; one latched record in flight
// The sink returns at most one credit per word it was sent
`timescale 1ns/1ps

`include "core_trace_consts.svh"

module trace_port_tx (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_trace_pkg::reg_rec_t  reg_head,
    input  logic                      reg_empty,
    input  core_trace_pkg::csr_rec_t  csr_head,
    input  logic                      csr_empty,
    input  logic                      trace_credit,
    output logic                      reg_pop,
    output logic                      csr_pop,
    output logic                      trace_valid,
    output core_trace_pkg::xword_t    trace_word
);

    localparam int CW = $clog2(`CT_TX_CREDITS + 1);

    core_trace_pkg::xword_t    frame     [`CT_CSR_WORDS];   // Latched record
    core_trace_pkg::xword_t    new_frame [`CT_CSR_WORDS];
    logic [3:0]                idx;
    logic [3:0]                len;
    logic                      busy;
    logic                      load;
    logic                      send;
    logic                      last;
    logic [CW-1:0]             credit;
    core_trace_pkg::xword_t    cur_word;

    // --------------------------------------
    // Arbitration and frame build
    // --------------------------------------
    assign reg_pop = ~busy & ~reg_empty;
    assign csr_pop = ~busy & reg_empty & ~csr_empty;
    assign load    = reg_pop | csr_pop;

    always_comb begin
        new_frame = '{default: '0};
        if (!reg_empty) begin
            new_frame[0][`CT_HDR_KIND_LSB +: `CT_HDR_FIELD_W] = `CT_HDR_FIELD_W'(`CT_KIND_REG);
            new_frame[0][`CT_HDR_LEN_LSB +: `CT_HDR_FIELD_W]  = `CT_HDR_FIELD_W'(`CT_REG_WORDS);
            new_frame[0][`CT_HDR_WR_BIT]                      = reg_head.wr;
            new_frame[0][`CT_REG_ADDR_W-1:0]                  = reg_head.addr;
            new_frame[1] = reg_head.stamp;
            new_frame[2] = reg_head.pc;
            new_frame[3] = reg_head.data;
        end else begin
            new_frame[0][`CT_HDR_KIND_LSB +: `CT_HDR_FIELD_W] = `CT_HDR_FIELD_W'(`CT_KIND_CSR);
            new_frame[0][`CT_HDR_LEN_LSB +: `CT_HDR_FIELD_W]  = `CT_HDR_FIELD_W'(`CT_CSR_WORDS);
            new_frame[1] = csr_head.stamp;
            new_frame[2] = csr_head.snap.mstatus;
            new_frame[3] = csr_head.snap.mtvec;
            new_frame[4] = csr_head.snap.mie;
            new_frame[5] = csr_head.snap.mip;
            new_frame[6] = csr_head.snap.mepc;
            new_frame[7] = csr_head.snap.mcause;
            new_frame[8] = csr_head.snap.mtval;
        end
    end

    // Header of a fresh record goes out in its load cycle when credit allows
    assign cur_word = busy ? frame[idx] : new_frame[0];
    assign last     = busy & (idx == len - 4'd1);
    assign send     = (busy | load) & (credit != '0);

    // --------------------------------------
    // Word sequencing
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
            len  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            idx  <= send ? 4'd1 : 4'd0;
            len  <= reg_pop ? 4'(`CT_REG_WORDS) : 4'(`CT_CSR_WORDS);
        end else if (send) begin
            if (last) begin
                busy <= 1'b0;                 // Record boundary, rearbitrate
            end else begin
                idx  <= idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            frame <= new_frame;
        end
    end

    // --------------------------------------
    // Credits and output register
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit      <= CW'(`CT_TX_CREDITS);
            trace_valid <= 1'b0;
        end else begin
            credit      <= credit + CW'(trace_credit) - CW'(send);
            trace_valid <= send;              // One cycle per word
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            trace_word <= cur_word;
        end
    end

    // Sink never returns more credits than words it received
    a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
        credit <= CW'(`CT_TX_CREDITS));

endmodule

// ==== logic/core_trace.sv ====
// Trace unit top: capture, two record queues, trace port
// Sink returns one credit pulse per consumed word
`timescale 1ns/1ps

`include "core_trace_consts.svh"

module core_trace (
    input  logic                          clk,
    input  logic                          rst_n,
    // Core events
    input  logic                          reg_wr_en,
    input  logic [`CT_REG_ADDR_W-1:0]     reg_wr_addr,
    input  logic [`CT_XLEN-1:0]           reg_wr_data,
    input  logic                          pc_update_en,
    input  logic [`CT_XLEN-1:0]           pc_update,
    input  logic                          mie_update,
    // CSR state
    input  logic                          mstatus_mie,
    input  logic                          mstatus_mpie,
    input  logic [`CT_XLEN-1:6]           mtvec_base,
    input  logic                          mtvec_mode,
    input  logic                          mie_meie,
    input  logic                          mie_mtie,
    input  logic                          mie_msie,
    input  logic                          mip_meip,
    input  logic                          mip_mtip,
    input  logic                          mip_msip,
    input  logic [`CT_XLEN-1:2]           mepc,
    input  logic                          mcause_irq,
    input  logic [`CT_MCAUSE_EC_W-1:0]    mcause_ec,
    input  logic [`CT_XLEN-1:0]           mtval,
    // Trace sink
    input  logic                          trace_credit,
    output logic                          trace_valid,
    output core_trace_pkg::xword_t        trace_word,
    output logic                          overflow
);

    logic                      reg_push, reg_pop, reg_empty, reg_full;
    logic                      csr_push, csr_pop, csr_empty, csr_full;
    core_trace_pkg::reg_rec_t  reg_rec, reg_head;
    core_trace_pkg::csr_rec_t  csr_rec, csr_head;

    trace_capture u_capture (
        .clk, .rst_n,
        .reg_wr_en, .reg_wr_addr, .reg_wr_data,
        .pc_update_en, .pc_update, .mie_update,
        .mstatus_mie, .mstatus_mpie, .mtvec_base, .mtvec_mode,
        .mie_meie, .mie_mtie, .mie_msie,
        .mip_meip, .mip_mtip, .mip_msip,
        .mepc, .mcause_irq, .mcause_ec, .mtval,
        .reg_full, .csr_full,
        .reg_push, .reg_rec, .csr_push, .csr_rec,
        .overflow
    );

    trace_fifo #(
        .payload_t (core_trace_pkg::reg_rec_t),
        .DEPTH     (`CT_REG_FIFO_DEPTH)
    ) u_reg_fifo (
        .clk, .rst_n,
        .push (reg_push), .push_data (reg_rec), .pop (reg_pop),
        .head (reg_head), .empty (reg_empty), .full (reg_full)
    );

    trace_fifo #(
        .payload_t (core_trace_pkg::csr_rec_t),
        .DEPTH     (`CT_CSR_FIFO_DEPTH)
    ) u_csr_fifo (
        .clk, .rst_n,
        .push (csr_push), .push_data (csr_rec), .pop (csr_pop),
        .head (csr_head), .empty (csr_empty), .full (csr_full)
    );

    trace_port_tx u_port_tx (
        .clk, .rst_n,
        .reg_head, .reg_empty, .csr_head, .csr_empty,
        .trace_credit,
        .reg_pop, .csr_pop,
        .trace_valid, .trace_word
    );

endmodule

// ==== testbench/core_trace_tb.sv ====
// Self-checking testbench for the trace unit
// Sink model returns one credit per received word; credits can be withheld
// Expected frames come from a model of the capture and framing rules
`timescale 1ns/1ps

`include "core_trace_consts.svh"

module core_trace_tb;

    // Estimated length of each test in cycles
    localparam int LEN_CSR_RESET    = 40;
    localparam int LEN_REG          = 120;
    localparam int LEN_NO_WRITE     = 40;
    localparam int LEN_CSR_CHANGE   = 120;
    localparam int LEN_ARB          = 50;
    localparam int LEN_BACKPRESSURE = 120;
    localparam int TIMEOUT_CYCLES   = 10 * (LEN_CSR_RESET + LEN_REG + LEN_NO_WRITE
                                            + LEN_CSR_CHANGE + LEN_ARB + LEN_BACKPRESSURE);
    localparam int REG_EVENTS       = 12;
    // Records the DUT holds with no credits: queue, frames already sent, latched one
    localparam int BP_ACCEPT        = `CT_REG_FIFO_DEPTH + `CT_TX_CREDITS / `CT_REG_WORDS + 1;
    localparam int BP_EVENTS        = BP_ACCEPT + 3;

    logic                       clk;
    logic                       rst_n;
    logic                       reg_wr_en;
    logic [`CT_REG_ADDR_W-1:0]  reg_wr_addr;
    logic [`CT_XLEN-1:0]        reg_wr_data;
    logic                       pc_update_en;
    logic [`CT_XLEN-1:0]        pc_update;
    logic                       mie_update;
    logic                       mstatus_mie;
    logic                       mstatus_mpie;
    logic [`CT_XLEN-1:6]        mtvec_base;
    logic                       mtvec_mode;
    logic                       mie_meie;
    logic                       mie_mtie;
    logic                       mie_msie;
    logic                       mip_meip;
    logic                       mip_mtip;
    logic                       mip_msip;
    logic [`CT_XLEN-1:2]        mepc;
    logic                       mcause_irq;
    logic [`CT_MCAUSE_EC_W-1:0] mcause_ec;
    logic [`CT_XLEN-1:0]        mtval;
    logic                       trace_credit;
    logic                       trace_valid;
    core_trace_pkg::xword_t     trace_word;
    logic                       overflow;

    core_trace_pkg::xword_t     exp_q [$];     // Expected words in arrival order
    integer                     seed = 24842;
    int                         tb_cycle;
    int                         run_cycles;
    int                         errors;
    int                         checks;
    int                         tests;
    int                         owed;          // Credits the sink still has to return
    int                         held_words;
    bit                         credit_on;

    core_trace UUT (.*);

    always #2 clk = ~clk;

    // Same stamp rule as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            tb_cycle <= 0;
        end else begin
            tb_cycle <= tb_cycle + 1;
        end
    end

    // ----------------------------------------
    // Compare tasks and reference model
    // ----------------------------------------
    task automatic check_word(input string name, input core_trace_pkg::xword_t exp,
                              input core_trace_pkg::xword_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    function automatic core_trace_pkg::xword_t bit_at(input logic b, input int pos);
        core_trace_pkg::xword_t w;
        w = '0;
        w[pos] = b;
        return w;
    endfunction

    // Snapshot as the core's CSR inputs stand now
    function automatic core_trace_pkg::csr_snap_t assemble_snap();
        core_trace_pkg::csr_snap_t s;
        s.mstatus = bit_at(mstatus_mie, `CT_MSTATUS_MIE_BIT)
                  | bit_at(mstatus_mpie, `CT_MSTATUS_MPIE_BIT)
                  | (core_trace_pkg::xword_t'(`CT_MSTATUS_MPP_VAL) << `CT_MSTATUS_MPP_LSB);
        s.mtvec   = {mtvec_base, 6'd0} | core_trace_pkg::xword_t'(mtvec_mode);
        s.mie     = bit_at(mie_msie, `CT_MIX_MSI_BIT) | bit_at(mie_mtie, `CT_MIX_MTI_BIT)
                  | bit_at(mie_meie, `CT_MIX_MEI_BIT);
        s.mip     = bit_at(mip_msip, `CT_MIX_MSI_BIT) | bit_at(mip_mtip, `CT_MIX_MTI_BIT)
                  | bit_at(mip_meip, `CT_MIX_MEI_BIT);
        s.mepc    = {mepc, 2'b00};
        s.mcause  = bit_at(mcause_irq, `CT_XLEN - 1) | core_trace_pkg::xword_t'(mcause_ec);
        s.mtval   = mtval;
        return s;
    endfunction

    function automatic core_trace_pkg::xword_t frame_header(input int kind, input int len,
                                                            input logic wr,
                                                            input logic [4:0] addr);
        return (core_trace_pkg::xword_t'(kind) << `CT_HDR_KIND_LSB)
             | (core_trace_pkg::xword_t'(len) << `CT_HDR_LEN_LSB)
             | bit_at(wr, `CT_HDR_WR_BIT) | core_trace_pkg::xword_t'(addr);
    endfunction

    // Appends the frame of one record to the expected words
    function automatic void expect_words(input bit is_csr, input core_trace_pkg::reg_rec_t r,
                                         input core_trace_pkg::csr_rec_t c);
        if (is_csr) begin
            exp_q.push_back(frame_header(`CT_KIND_CSR, `CT_CSR_WORDS, 1'b0, 5'd0));
            exp_q.push_back(c.stamp);
            exp_q.push_back(c.snap.mstatus);
            exp_q.push_back(c.snap.mtvec);
            exp_q.push_back(c.snap.mie);
            exp_q.push_back(c.snap.mip);
            exp_q.push_back(c.snap.mepc);
            exp_q.push_back(c.snap.mcause);
            exp_q.push_back(c.snap.mtval);
        end else begin
            exp_q.push_back(frame_header(`CT_KIND_REG, `CT_REG_WORDS, r.wr, r.addr));
            exp_q.push_back(r.stamp);
            exp_q.push_back(r.pc);
            exp_q.push_back(r.data);
        end
    endfunction

    // ----------------------------------------
    // Sink: word checker and credit return
    // ----------------------------------------
    always begin
        @(posedge clk);
        #1;
        if (trace_valid === 1'b1) begin
            owed++;
            if (!credit_on) held_words++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR time=%0t: word %h arrived with no record expected",
                         $time, trace_word);
            end else begin
                check_word("trace_word", exp_q.pop_front(), trace_word);
            end
        end
        if (credit_on && owed > 0) begin
            trace_credit = 1'b1;
            owed--;
        end else begin
            trace_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles == TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles, %0d words never arrived",
                     run_cycles, exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_credits(input bit on);
        @(negedge clk);
        credit_on = on;
    endtask

    // Drives one core cycle; keep is low for records the model drops
    task automatic retire(input logic pc_en, input logic wr, input logic mie_up,
                          input logic [`CT_REG_ADDR_W-1:0] addr,
                          input core_trace_pkg::xword_t data,
                          input core_trace_pkg::xword_t pc, input bit keep);
        core_trace_pkg::reg_rec_t r;
        pc_update_en = pc_en;
        pc_update    = pc;
        reg_wr_en    = wr;
        reg_wr_addr  = addr;
        reg_wr_data  = data;
        mie_update   = mie_up;
        r.stamp = tb_cycle;
        r.pc    = pc;
        r.wr    = wr;
        r.addr  = wr ? addr : '0;
        r.data  = wr ? data : '0;
        if ((pc_en || (wr && !mie_up)) && keep) expect_words(1'b0, r, '0);
    endtask

    task automatic quiet();
        pc_update_en = 1'b0;
        reg_wr_en    = 1'b0;
        mie_update   = 1'b0;
    endtask

    task automatic change_csr_field();
        int                     sel;
        core_trace_pkg::xword_t r;
        core_trace_pkg::csr_rec_t c;
        sel = $unsigned($random(seed)) % 7;
        r   = $random(seed);
        case (sel)
            0: mtval = mtval ^ (r | 32'd1);
            1: mepc = mepc ^ (r[29:0] | 30'd1);
            2: begin
                mtvec_base = mtvec_base ^ (r[25:0] | 26'd1);
                mtvec_mode = r[31];
            end
            3: begin
                mcause_irq = ~mcause_irq;
                mcause_ec  = r[3:0];
            end
            4: begin
                mie_mtie = ~mie_mtie;
                mie_msie = r[0];
                mie_meie = r[1];
            end
            5: begin
                mip_meip = ~mip_meip;
                mip_mtip = r[0];
                mip_msip = r[1];
            end
            default: begin
                mstatus_mie  = ~mstatus_mie;
                mstatus_mpie = r[0];
            end
        endcase
        c.stamp = tb_cycle;
        c.snap  = assemble_snap();
        expect_words(1'b1, '0, c);
    endtask

    // Waits for all expected words, then idles so stray frames show up
    task automatic drain(input int idle_cycles);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (idle_cycles) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %s: ok at %0t", name, $time);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int err_start;
        clk = 1'b0;
        rst_n = 1'b0;
        trace_credit = 1'b0;
        credit_on = 1'b1;
        quiet();
        pc_update = '0;
        reg_wr_addr = '0;
        reg_wr_data = '0;
        {mstatus_mie, mstatus_mpie, mtvec_base, mtvec_mode} = '0;
        {mie_meie, mie_mtie, mie_msie, mip_meip, mip_mtip, mip_msip} = '0;
        {mepc, mcause_irq, mcause_ec, mtval} = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // First cycle out of reset carries the reset snapshot
        err_start = errors;
        expect_words(1'b1, '0, '{stamp: tb_cycle, snap: assemble_snap()});
        drain(12);
        finish_test("csr_reset", err_start);

        err_start = errors;
        for (int i = 0; i < REG_EVENTS; i++) begin
            next_cycle();
            retire(1'b1, 1'b1, 1'b0, 5'($random(seed)), $random(seed),
                   $random(seed) & 32'hffff_fffc, 1'b1);
            next_cycle();
            quiet();
        end
        drain(12);
        check_bit("overflow", 1'b0, overflow);
        finish_test("reg_writes", err_start);

        err_start = errors;
        next_cycle();
        retire(1'b1, 1'b0, 1'b0, 5'd9, 32'hdead_beef, 32'h0000_0400, 1'b1);
        next_cycle();
        retire(1'b0, 1'b1, 1'b1, 5'd3, 32'h1234_5678, 32'h0000_0404, 1'b1);
        next_cycle();
        quiet();
        drain(12);
        finish_test("no_write", err_start);

        err_start = errors;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            change_csr_field();
            drain(12);
        end
        finish_test("csr_change", err_start);

        // Register frame must lead when both queues fill in one cycle
        err_start = errors;
        next_cycle();
        retire(1'b1, 1'b1, 1'b0, 5'd17, 32'h0bad_f00d, 32'h0000_0800, 1'b1);
        change_csr_field();
        next_cycle();
        quiet();
        drain(12);
        check_bit("overflow", 1'b0, overflow);
        finish_test("arbitration", err_start);

        err_start = errors;
        held_words = 0;
        set_credits(1'b0);
        for (int i = 0; i < BP_EVENTS; i++) begin
            next_cycle();
            retire(1'b1, 1'b1, 1'b0, 5'($random(seed)), $random(seed),
                   $random(seed) & 32'hffff_fffc, i < BP_ACCEPT);
        end
        next_cycle();
        quiet();
        repeat (8) next_cycle();
        check_bit("overflow", 1'b1, overflow);
        if (held_words > `CT_TX_CREDITS) begin
            errors++;
            $display("ERROR: %0d words sent without credits, limit is %0d",
                     held_words, `CT_TX_CREDITS);
        end
        set_credits(1'b1);
        drain(12);
        finish_test("backpressure", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== core_trace.f ====
+incdir+include
logic/core_trace_pkg.sv
logic/trace_capture.sv
logic/trace_fifo.sv
logic/trace_port_tx.sv
logic/core_trace.sv
testbench/core_trace_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the trace unit testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/core_trace_sim

verilator --binary --timing --assert -Wno-fatal \
    -f core_trace.f --top-module core_trace_tb \
    -Mdir obj_dir -o core_trace_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
